//--- Makefile
# Verilator build for the vector CSR register block

VERILATOR ?= verilator
TOP       ?= tb_vec_csr_regfile
FILELIST  ?= vec_csr_regfile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= STATUS: PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- csr_access.sv
`timescale 1ns/10ps

module csr_access (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic [vec_csr_pkg::XLEN-1:0]  inst,
    input  logic [vec_csr_pkg::XLEN-1:0]  scalar1,    // rs1 value or zero-extended uimm
    input  vec_csr_pkg::vtype_u           vtype_q,
    input  logic [vec_csr_pkg::XLEN-1:0]  vl_q,
    output logic [vec_csr_pkg::XLEN-1:0]  csr_out,
    output logic [vec_csr_pkg::XLEN-1:0]  vstart_q
);

    import vec_csr_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [4:0]      rs1_addr;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] vstart_d;
    logic [XLEN-1:0] ro_rdata;
    logic            ro_read;

    //////////////////////////////
    // instruction fields
    //////////////////////////////

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign csr_addr = inst[31:20];

    // vtype and vl are read only, so any write intent blocks the read
    always_comb begin
        ro_rdata = '0;
        case (csr_addr)
            CSR_VTYPE: ro_rdata = vtype_q.raw;
            CSR_VL:    ro_rdata = vl_q;
            default:   ro_rdata = '0;
        endcase
    end

    assign ro_read = (rs1_addr == 5'd0);

    //////////////////////////////
    // read mux and vstart update
    //////////////////////////////

    always_comb begin
        csr_out  = '0;
        vstart_d = vstart_q;                            // hold unless written
        if (opcode == OPC_SYSTEM) begin
            case (funct3)
                F3_CSRRW, F3_CSRRWI: begin
                    if (csr_addr == CSR_VSTART) begin
                        csr_out  = vstart_q;
                        vstart_d = scalar1;
                    end
                end
                F3_CSRRS, F3_CSRRSI: begin
                    if (csr_addr == CSR_VSTART) begin
                        csr_out  = vstart_q;
                        vstart_d = vstart_q | scalar1;  // set bits
                    end else if (ro_read) begin
                        csr_out  = ro_rdata;
                    end
                end
                F3_CSRRC, F3_CSRRCI: begin
                    if (csr_addr == CSR_VSTART) begin
                        csr_out  = vstart_q;
                        vstart_d = vstart_q & ~scalar1; // clear bits
                    end else if (ro_read) begin
                        csr_out  = ro_rdata;
                    end
                end
                default: begin
                    csr_out  = '0;                      // funct3 0 and 4 not csr ops
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vstart_q <= '0;
        end else begin
            vstart_q <= vstart_d;
        end
    end

endmodule

//--- mem_elem_decode.sv
`timescale 1ns/10ps

module mem_elem_decode (
    input  logic                                mew,
    input  logic [2:0]                          width,      // memory element width
    input  vec_csr_pkg::vtype_u                 vtype_q,
    output logic [vec_csr_pkg::EW_W-1:0]        eew,
    output logic [vec_csr_pkg::EMUL_W-1:0]      emul,
    output logic [vec_csr_pkg::VLMAX_W-1:0]     e_vlmax
);

    import vec_csr_pkg::*;

    logic [2:0] eew_sh;
    logic [1:0] lmul_sh;
    logic [2:0] sew_sh;
    logic       lmul_rsvd;
    logic [3:0] emul_num_sh;    // log2(eew * lmul)
    logic [3:0] emul_den_sh;    // log2(sew)

    //////////////////////////////
    // element width
    //////////////////////////////

    always_comb begin
        case ({mew, width})
            4'b0_000: eew_sh = 3'd3;    // 8
            4'b0_101: eew_sh = 3'd4;    // 16
            4'b0_110: eew_sh = 3'd5;    // 32
            4'b0_111: eew_sh = 3'd6;    // 64
            default:  eew_sh = 3'd5;    // unsupported widths decode as 32
        endcase
    end

    assign eew = EW_W'(1) << eew_sh;

    //////////////////////////////
    // emul = eew * lmul / sew
    //////////////////////////////

    assign lmul_sh     = lmul_shift(vtype_q.fields.vlmul);
    assign sew_sh      = sew_shift(vtype_q.fields.vsew);
    assign lmul_rsvd   = vtype_q.fields.vlmul[2];
    assign emul_num_sh = {1'b0, eew_sh} + {2'b00, lmul_sh};
    assign emul_den_sh = {1'b0, sew_sh};

    always_comb begin
        if (lmul_rsvd) begin
            emul = EMUL_W'(1);
        end else if (emul_num_sh < emul_den_sh) begin
            emul = '0;                                  // fractional emul truncates
        end else begin
            emul = EMUL_W'(1) << (emul_num_sh - emul_den_sh);   // up to 64 without limit
        end
    end

    // element vlmax = vlen / eew * emul
    assign e_vlmax = VLMAX_W'((VLEN >> eew_sh) * emul);

endmodule

//--- tb_vec_csr_regfile.sv
`timescale 1ns/10ps

module tb_vec_csr_regfile;

    import vec_csr_pkg::*;

    localparam int CYC_RESET    = 6;
    localparam int CYC_STATE    = 4;
    localparam int CYC_CAPTURE  = 64 * 3 + 4;
    localparam int CYC_HOLD     = 12;
    localparam int CYC_MEM      = 6 * 9 + 4;
    localparam int CYC_VSTART   = 6 * 8 + 4;
    localparam int CYC_READBACK = 14;
    localparam int CYC_TOTAL    = CYC_RESET + CYC_STATE + CYC_CAPTURE + CYC_HOLD + CYC_MEM
                                  + CYC_VSTART + CYC_READBACK;
    localparam int TIMEOUT_NS   = CYC_TOTAL * 8 * 2;

    logic               clk;
    logic               n_rst;
    logic [XLEN-1:0]    inst;
    logic [XLEN-1:0]    scalar1;
    logic [XLEN-1:0]    scalar2;
    logic               mew;
    logic [2:0]         width;
    logic               csrwr_en;
    logic [XLEN-1:0]    csr_out;
    logic [LMUL_W-1:0]  vlmul;
    logic [EW_W-1:0]    sew;
    logic [VLMAX_W-1:0] vlmax;
    logic [EW_W-1:0]    eew;
    logic [EMUL_W-1:0]  emul;
    logic [VLMAX_W-1:0] e_vlmax;
    logic               tail_agnostic;
    logic               mask_agnostic;
    logic [XLEN-1:0]    vec_length;
    logic [XLEN-1:0]    start_element;
    logic               csr_done;

    integer      seed;
    int          errors;
    int          checks;
    int          tests_run;
    int          prev_errors;
    logic [31:0] model_vl;      // expected vl
    logic [31:0] model_vtype;   // expected vtype readback
    logic [31:0] model_vstart;

    vec_csr_regfile vec_csr_regfile_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .inst          (inst),
        .scalar1       (scalar1),
        .scalar2       (scalar2),
        .mew           (mew),
        .width         (width),
        .csrwr_en      (csrwr_en),
        .csr_out       (csr_out),
        .vlmul         (vlmul),
        .sew           (sew),
        .vlmax         (vlmax),
        .eew           (eew),
        .emul          (emul),
        .e_vlmax       (e_vlmax),
        .tail_agnostic (tail_agnostic),
        .mask_agnostic (mask_agnostic),
        .vec_length    (vec_length),
        .start_element (start_element),
        .csr_done      (csr_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic int lmul_of(input logic [2:0] code);
        case (code)
            3'd0:    return 1;
            3'd1:    return 2;
            3'd2:    return 4;
            3'd3:    return 8;
            default: return 1;    // reserved
        endcase
    endfunction

    function automatic int sew_of(input logic [2:0] code);
        case (code)
            3'd0:    return 8;
            3'd1:    return 16;
            3'd2:    return 32;
            3'd3:    return 64;
            default: return 32;   // reserved
        endcase
    endfunction

    function automatic int vlmax_of(input logic [2:0] lm, input logic [2:0] sw);
        if (lm > 3'd3) begin
            return 16;
        end
        return VLEN * lmul_of(lm) / sew_of(sw);
    endfunction

    function automatic int eew_of(input logic m, input logic [2:0] w);
        if (m) begin
            return 32;
        end
        case (w)
            3'd0:    return 8;
            3'd5:    return 16;
            3'd6:    return 32;
            3'd7:    return 64;
            default: return 32;
        endcase
    endfunction

    function automatic int emul_of(input logic [2:0] lm, input logic [2:0] sw,
                                   input logic m, input logic [2:0] w);
        if (lm > 3'd3) begin
            return 1;
        end
        return eew_of(m, w) * lmul_of(lm) / sew_of(sw);    // fractions drop to 0
    endfunction

    function automatic int elem_vlmax_of(input logic [2:0] lm, input logic [2:0] sw,
                                         input logic m, input logic [2:0] w);
        return VLEN / eew_of(m, w) * emul_of(lm, sw, m, w);
    endfunction

    function automatic logic [31:0] build_csr_inst(input logic [11:0] addr,
                                                   input logic [4:0] rs1,
                                                   input logic [2:0] f3,
                                                   input logic [6:0] opc);
        return {addr, rs1, f3, 5'd1, opc};    // rd fixed at x1
    endfunction

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, errors - prev_errors);
        prev_errors = errors;
        tests_run++;
    endtask

    // called right after a falling edge and returns on one
    task automatic write_config(input logic [31:0] vl_val, input logic [31:0] vt_val);
        csrwr_en = 1'b1;
        scalar1  = vl_val;
        scalar2  = vt_val;
        @(negedge clk);
        compare("csr_done", 32'(csr_done), 32'd1);
        csrwr_en = 1'b0;
        @(negedge clk);
        compare("csr_done", 32'(csr_done), 32'd0);    // pulse is one cycle wide
        model_vl    = vl_val;
        model_vtype = {24'b0, vt_val[7:0]};
    endtask

    task automatic run_csr_op(input string name, input logic [31:0] word,
                              input logic [31:0] operand, input logic [31:0] exp_out,
                              input logic [31:0] exp_vstart);
        inst    = word;
        scalar1 = operand;
        #2;
        compare({name, " csr_out"}, csr_out, exp_out);    // old value in the same cycle
        @(negedge clk);
        compare({name, " start_element"}, start_element, exp_vstart);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic check_reset_state();
        inst = build_csr_inst(CSR_VTYPE, 5'd0, F3_CSRRS, OPC_SYSTEM);
        #2;
        compare("csr_done", 32'(csr_done), 32'd0);
        compare("vec_length", vec_length, 32'd0);
        compare("start_element", start_element, 32'd0);
        compare("vtype readback", csr_out, 32'h8000_0000);
        compare("vlmul", 32'(vlmul), 32'(lmul_of(3'd0)));
        compare("sew", 32'(sew), 32'(sew_of(3'd0)));
        compare("vlmax", 32'(vlmax), 32'(vlmax_of(3'd0, 3'd0)));
        @(negedge clk);
        finish_test("reset_state");
    endtask

    task automatic sweep_config_capture();
        logic [31:0] r;
        logic [31:0] vl_val;
        for (int lm = 0; lm < 8; lm++) begin
            for (int sw = 0; sw < 8; sw++) begin
                r      = $random(seed);
                vl_val = $random(seed);
                write_config(vl_val, {r[31:8], r[1], r[0], 3'(sw), 3'(lm)});
                inst = build_csr_inst(CSR_VTYPE, 5'd0, F3_CSRRS, OPC_SYSTEM);
                #2;
                compare("vlmul", 32'(vlmul), 32'(lmul_of(3'(lm))));
                compare("sew", 32'(sew), 32'(sew_of(3'(sw))));
                compare("vlmax", 32'(vlmax), 32'(vlmax_of(3'(lm), 3'(sw))));
                compare("tail_agnostic", 32'(tail_agnostic), 32'(r[0]));
                compare("mask_agnostic", 32'(mask_agnostic), 32'(r[1]));
                compare("vec_length", vec_length, model_vl);
                compare("vtype readback", csr_out, model_vtype);
                compare("vtype ill", 32'(csr_out[31]), 32'd0);
                @(negedge clk);
            end
        end
        finish_test("config_capture");
    endtask

    task automatic hold_strobe();
        logic [31:0] first_vl;
        logic [31:0] first_vtype;
        int          pulses;
        first_vl    = $random(seed);
        first_vtype = $random(seed);
        pulses      = 0;
        csrwr_en    = 1'b1;
        scalar1     = first_vl;
        scalar2     = first_vtype;
        repeat (5) begin
            @(negedge clk);
            if (csr_done) pulses++;
            scalar1 = $random(seed);    // must not be captured
            scalar2 = $random(seed);
        end
        csrwr_en = 1'b0;
        repeat (2) begin
            @(negedge clk);
            if (csr_done) pulses++;
        end
        compare("csr_done pulses", 32'(pulses), 32'd1);
        model_vl    = first_vl;
        model_vtype = {24'b0, first_vtype[7:0]};
        inst = build_csr_inst(CSR_VTYPE, 5'd0, F3_CSRRS, OPC_SYSTEM);
        #2;
        compare("vec_length", vec_length, model_vl);
        compare("vtype readback", csr_out, model_vtype);
        @(negedge clk);
        finish_test("held_strobe");
    endtask

    task automatic sweep_mem_decode();
        logic [7:0] vtypes [6];
        logic [3:0] widths [7];
        logic [2:0] lm;
        logic [2:0] sw;
        vtypes = '{8'b00_011_000, 8'b00_000_011, 8'b01_001_001,
                   8'b10_010_010, 8'b00_010_101, 8'b11_110_001};
        widths = '{4'b0000, 4'b0101, 4'b0110, 4'b0111, 4'b0001, 4'b0100, 4'b1000};
        foreach (vtypes[v]) begin
            write_config($random(seed), {24'b0, vtypes[v]});
            lm = vtypes[v][2:0];
            sw = vtypes[v][5:3];
            foreach (widths[k]) begin
                mew   = widths[k][3];
                width = widths[k][2:0];
                #2;
                compare("eew", 32'(eew), 32'(eew_of(mew, width)));
                compare("emul", 32'(emul), 32'(emul_of(lm, sw, mew, width)));
                compare("e_vlmax", 32'(e_vlmax), 32'(elem_vlmax_of(lm, sw, mew, width)));
                @(negedge clk);
            end
        end
        finish_test("mem_decode");
    endtask

    task automatic exercise_vstart();
        logic [2:0]  forms [6];
        logic [31:0] operand;
        logic [31:0] next_vstart;
        logic [4:0]  rs1;
        forms = '{F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};
        foreach (forms[f]) begin
            repeat (8) begin
                operand = $random(seed);
                if (forms[f][2]) begin
                    operand = {27'b0, operand[4:0]};    // zero-extended uimm
                    rs1     = operand[4:0];
                end else begin
                    rs1 = operand[9:5];
                end
                case (forms[f][1:0])
                    2'b01:   next_vstart = operand;
                    2'b10:   next_vstart = model_vstart | operand;
                    default: next_vstart = model_vstart & ~operand;
                endcase
                run_csr_op("vstart", build_csr_inst(CSR_VSTART, rs1, forms[f], OPC_SYSTEM),
                           operand, model_vstart, next_vstart);
                model_vstart = next_vstart;
            end
        end
        inst = 32'h0000_0013;    // addi x0, x0, 0
        finish_test("vstart_ops");
    endtask

    task automatic check_readback_rules();
        run_csr_op("csrrs vl", build_csr_inst(CSR_VL, 5'd0, F3_CSRRS, OPC_SYSTEM),
                   32'd0, model_vl, model_vstart);
        run_csr_op("csrrs vtype", build_csr_inst(CSR_VTYPE, 5'd0, F3_CSRRS, OPC_SYSTEM),
                   32'd0, model_vtype, model_vstart);
        run_csr_op("csrrc vtype", build_csr_inst(CSR_VTYPE, 5'd0, F3_CSRRC, OPC_SYSTEM),
                   32'd0, model_vtype, model_vstart);
        run_csr_op("csrrsi vl", build_csr_inst(CSR_VL, 5'd0, F3_CSRRSI, OPC_SYSTEM),
                   32'd0, model_vl, model_vstart);
        run_csr_op("csrrs vl rs1", build_csr_inst(CSR_VL, 5'd3, F3_CSRRS, OPC_SYSTEM),
                   $random(seed), 32'd0, model_vstart);
        run_csr_op("csrrw vtype", build_csr_inst(CSR_VTYPE, 5'd2, F3_CSRRW, OPC_SYSTEM),
                   $random(seed), 32'd0, model_vstart);
        run_csr_op("unknown csr", build_csr_inst(12'h123, 5'd0, F3_CSRRS, OPC_SYSTEM),
                   $random(seed), 32'd0, model_vstart);
        run_csr_op("non-system", build_csr_inst(CSR_VSTART, 5'd4, F3_CSRRW, 7'h33),
                   $random(seed), 32'd0, model_vstart);
        run_csr_op("funct3 0", build_csr_inst(CSR_VSTART, 5'd5, 3'd0, OPC_SYSTEM),
                   $random(seed), 32'd0, model_vstart);
        run_csr_op("funct3 4", build_csr_inst(CSR_VSTART, 5'd6, 3'd4, OPC_SYSTEM),
                   $random(seed), 32'd0, model_vstart);
        inst = 32'h0000_0013;
        finish_test("readback_rules");
    endtask

    initial begin
        seed         = 32'ha1b4_f091;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        prev_errors  = 0;
        model_vl     = '0;
        model_vtype  = 32'h8000_0000;
        model_vstart = '0;
        n_rst        = 1'b0;
        inst         = '0;
        scalar1      = '0;
        scalar2      = '0;
        mew          = 1'b0;
        width        = 3'd0;
        csrwr_en     = 1'b0;
        repeat (4) @(negedge clk);
        n_rst = 1'b1;

        check_reset_state();
        sweep_config_capture();
        hold_strobe();
        sweep_mem_decode();
        exercise_vstart();
        check_readback_rules();

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- vec_csr_pkg.sv
package vec_csr_pkg;

    //////////////////////////////
    // widths and limits
    //////////////////////////////

    localparam int XLEN    = 32;
    localparam int VLEN    = 512;   // vector register bits
    localparam int VLMAX_W = 10;    // holds 512
    localparam int LMUL_W  = 4;
    localparam int EW_W    = 7;     // sew and eew
    localparam int EMUL_W  = 7;     // holds 64

    //////////////////////////////
    // instruction codes
    //////////////////////////////

    localparam logic [6:0] OPC_SYSTEM = 7'h73;

    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    localparam logic [11:0] CSR_VSTART = 12'h008;
    localparam logic [11:0] CSR_VL     = 12'hC20;   // read only
    localparam logic [11:0] CSR_VTYPE  = 12'hC21;   // read only

    // codes 4..7 reserved in both
    typedef enum logic [2:0] {LMUL_1 = 3'd0, LMUL_2, LMUL_4, LMUL_8} vlmul_e;
    typedef enum logic [2:0] {EW8 = 3'd0, EW16, EW32, EW64} vew_e;

    // csr readback word and its field view
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic        ill;
            logic [22:0] reserved;
            logic        vma;
            logic        vta;
            logic [2:0]  vsew;
            logic [2:0]  vlmul;
        } fields;
    } vtype_u;

    // log2 of lmul where reserved codes act as lmul 1
    function automatic logic [1:0] lmul_shift(logic [2:0] code);
        case (vlmul_e'(code))
            LMUL_1:  return 2'd0;
            LMUL_2:  return 2'd1;
            LMUL_4:  return 2'd2;
            LMUL_8:  return 2'd3;
            default: return 2'd0;
        endcase
    endfunction

    // log2 of sew where reserved codes act as 32 bits
    function automatic logic [2:0] sew_shift(logic [2:0] code);
        case (vew_e'(code))
            EW8:     return 3'd3;
            EW16:    return 3'd4;
            EW32:    return 3'd5;
            EW64:    return 3'd6;
            default: return 3'd5;
        endcase
    endfunction

endpackage

//--- vec_csr_regfile.f
vec_csr_pkg.sv
vtype_config.sv
vtype_decode.sv
mem_elem_decode.sv
csr_access.sv
vec_csr_regfile.sv
tb_vec_csr_regfile.sv

//--- vec_csr_regfile.sv
`timescale 1ns/10ps

module vec_csr_regfile (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic [vec_csr_pkg::XLEN-1:0]        inst,
    input  logic [vec_csr_pkg::XLEN-1:0]        scalar1,        // vl / csr operand
    input  logic [vec_csr_pkg::XLEN-1:0]        scalar2,        // vtype
    input  logic                                mew,
    input  logic [2:0]                          width,
    input  logic                                csrwr_en,
    output logic [vec_csr_pkg::XLEN-1:0]        csr_out,
    output logic [vec_csr_pkg::LMUL_W-1:0]      vlmul,
    output logic [vec_csr_pkg::EW_W-1:0]        sew,
    output logic [vec_csr_pkg::VLMAX_W-1:0]     vlmax,
    output logic [vec_csr_pkg::EW_W-1:0]        eew,
    output logic [vec_csr_pkg::EMUL_W-1:0]      emul,
    output logic [vec_csr_pkg::VLMAX_W-1:0]     e_vlmax,
    output logic                                tail_agnostic,
    output logic                                mask_agnostic,
    output logic [vec_csr_pkg::XLEN-1:0]        vec_length,
    output logic [vec_csr_pkg::XLEN-1:0]        start_element,
    output logic                                csr_done
);

    import vec_csr_pkg::*;

    vtype_u          vtype_q;
    logic [XLEN-1:0] vl_q;
    logic [XLEN-1:0] vstart_q;

    vtype_config vtype_config_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .csrwr_en  (csrwr_en),
        .scalar1   (scalar1),
        .scalar2   (scalar2),
        .vtype_q   (vtype_q),
        .vl_q      (vl_q),
        .csr_done  (csr_done)
    );

    vtype_decode vtype_decode_i (
        .vtype_q        (vtype_q),
        .vlmul          (vlmul),
        .sew            (sew),
        .vlmax          (vlmax),
        .tail_agnostic  (tail_agnostic),
        .mask_agnostic  (mask_agnostic)
    );

    mem_elem_decode mem_elem_decode_i (
        .mew      (mew),
        .width    (width),
        .vtype_q  (vtype_q),
        .eew      (eew),
        .emul     (emul),
        .e_vlmax  (e_vlmax)
    );

    csr_access csr_access_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .inst      (inst),
        .scalar1   (scalar1),
        .vtype_q   (vtype_q),
        .vl_q      (vl_q),
        .csr_out   (csr_out),
        .vstart_q  (vstart_q)
    );

    assign vec_length    = vl_q;
    assign start_element = vstart_q;

endmodule

//--- vtype_config.sv
`timescale 1ns/10ps

module vtype_config (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          csrwr_en,
    input  logic [vec_csr_pkg::XLEN-1:0]  scalar1,    // new vl
    input  logic [vec_csr_pkg::XLEN-1:0]  scalar2,    // new vtype
    output vec_csr_pkg::vtype_u           vtype_q,
    output logic [vec_csr_pkg::XLEN-1:0]  vl_q,
    output logic                          csr_done
);

    import vec_csr_pkg::*;

    logic   csrwr_en_d;
    logic   cfg_rise;
    vtype_u wr_vtype;

    assign cfg_rise = csrwr_en & ~csrwr_en_d;    // level strobe to one edge
    assign wr_vtype = vtype_u'(scalar2);         // low byte in vtype layout

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            csrwr_en_d <= 1'b0;
        end else begin
            csrwr_en_d <= csrwr_en;
        end
    end

    //////////////////////////////
    // configuration capture
    //////////////////////////////

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vtype_q.raw <= {1'b1, {(XLEN-1){1'b0}}};    // ill set until first vsetvl
            vl_q        <= '0;
            csr_done    <= 1'b0;
        end else begin
            csr_done <= cfg_rise;                        // single cycle pulse
            if (cfg_rise) begin
                vtype_q.fields.ill      <= 1'b0;
                vtype_q.fields.reserved <= '0;
                vtype_q.fields.vma      <= wr_vtype.fields.vma;
                vtype_q.fields.vta      <= wr_vtype.fields.vta;
                vtype_q.fields.vsew     <= wr_vtype.fields.vsew;
                vtype_q.fields.vlmul    <= wr_vtype.fields.vlmul;
                vl_q                    <= scalar1;
            end
        end
    end

endmodule

//--- vtype_decode.sv
`timescale 1ns/10ps

module vtype_decode (
    input  vec_csr_pkg::vtype_u                 vtype_q,
    output logic [vec_csr_pkg::LMUL_W-1:0]      vlmul,
    output logic [vec_csr_pkg::EW_W-1:0]        sew,
    output logic [vec_csr_pkg::VLMAX_W-1:0]     vlmax,
    output logic                                tail_agnostic,
    output logic                                mask_agnostic
);

    import vec_csr_pkg::*;

    logic [1:0] lmul_sh;
    logic [2:0] sew_sh;
    logic       lmul_rsvd;

    //////////////////////////////
    // lmul and sew
    //////////////////////////////

    assign lmul_sh   = lmul_shift(vtype_q.fields.vlmul);
    assign sew_sh    = sew_shift(vtype_q.fields.vsew);
    assign lmul_rsvd = vtype_q.fields.vlmul[2];      // codes 4..7

    assign vlmul = LMUL_W'(1) << lmul_sh;            // 1, 2, 4, 8
    assign sew   = EW_W'(1) << sew_sh;               // 8 .. 64

    //////////////////////////////
    // vlmax = vlen * lmul / sew
    //////////////////////////////

    // all terms are powers of two, so the divide is a right shift
    always_comb begin
        if (lmul_rsvd) begin
            vlmax = VLMAX_W'(16);                    // fixed for reserved lmul
        end else begin
            vlmax = VLMAX_W'((VLEN << lmul_sh) >> sew_sh);
        end
    end

    assign tail_agnostic = vtype_q.fields.vta;
    assign mask_agnostic = vtype_q.fields.vma;

endmodule
